//--- Makefile
# Verilator build of the decode pipeline testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_top \
		-Mdir obj_dir -f decode_pipe.f
	./obj_dir/Vtb_decode_top

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- decode_pipe.f
rtl/decode_pkg.sv
rtl/stage_link.sv
rtl/prefix_stage.sv
rtl/opcode_stage.sv
rtl/extract_stage.sv
rtl/decode_top.sv
tests/tb_decode_top.sv

//--- rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int packet_bytes = 16;      // one fetch packet
    localparam int eip_w        = 32;
    localparam int len_w        = 5;       // lengths 0..16
    localparam int disp_w       = 32;
    localparam int imm_w        = 48;      // far pointer is the widest
    localparam int max_prefixes = 3;

    // prefix bytes
    localparam logic [7:0] pfx_rep    = 8'hf3;
    localparam logic [7:0] pfx_opsize = 8'h66;
    localparam logic [7:0] pfx_es     = 8'h26;
    localparam logic [7:0] pfx_cs     = 8'h2e;
    localparam logic [7:0] pfx_ss     = 8'h36;
    localparam logic [7:0] pfx_ds     = 8'h3e;
    localparam logic [7:0] pfx_fs     = 8'h64;
    localparam logic [7:0] pfx_gs     = 8'h65;

    localparam logic [7:0] op_escape  = 8'h0f;  // two byte opcode map

    //////////////////////////////////////////////////
    // payload types
    //////////////////////////////////////////////////

    // byte 0 sits in bits 127:120
    typedef logic [0:packet_bytes-1][7:0] packet_t;

    typedef enum logic [2:0] {
        seg_es = 3'd0,
        seg_cs = 3'd1,
        seg_ss = 3'd2,
        seg_ds = 3'd3,
        seg_fs = 3'd4,
        seg_gs = 3'd5
    } seg_e;

    typedef struct packed {
        logic       rep;
        logic       opsize16;
        logic       seg_ovr;
        seg_e       seg;
        logic [1:0] num_prefixes;   // 0..3
    } prefix_info_t;

    typedef struct packed {
        prefix_info_t     pfx;
        logic [7:0]       opcode;
        logic             is_double;
        logic             has_modrm;
        logic [2:0]       reg_num;  // modrm reg field
        logic [2:0]       base;
        logic             use_base;
        logic [2:0]       index;
        logic             use_index;
        logic [1:0]       scale;
        logic [3:0]       disp_off; // byte offsets into the packet
        logic [2:0]       disp_size;
        logic [3:0]       imm_off;
        logic [2:0]       imm_size;
        logic [len_w-1:0] length;
        logic             illegal;
    } decoded_t;

    //////////////////////////////////////////////////
    // opcode table
    //////////////////////////////////////////////////

    // v resolves to 4 or 2 bytes, far to 6 or 4, by opsize16
    typedef enum logic [2:0] {imm_none, imm_1, imm_2, imm_v, imm_far} imm_code_e;

    typedef struct packed {
        logic      modrm;
        imm_code_e imm;
        logic      legal;
    } op_info_t;

    function automatic op_info_t op_lookup(input logic is_double, input logic [7:0] op);
        op_info_t info;
        info = '{modrm: 1'b0, imm: imm_none, legal: 1'b1};
        if (is_double) begin
            if (op[7:4] == 4'h8) info.imm = imm_v;  // jcc rel32
            else                 info.legal = 1'b0;
        end else begin
            case (op) inside
                8'h00, 8'h01, 8'h02, 8'h03,
                [8'h88:8'h8b]:               info.modrm = 1'b1;  // alu / mov r,rm
                8'h04, 8'heb:                info.imm = imm_1;
                8'h05, [8'hb8:8'hbf], 8'he8: info.imm = imm_v;
                [8'h40:8'h5f], 8'h90, 8'hc3: info.imm = imm_none; // no operands in stream
                8'h80, 8'h83: begin
                    info.modrm = 1'b1;
                    info.imm   = imm_1;
                end
                8'h81: begin
                    info.modrm = 1'b1;
                    info.imm   = imm_v;
                end
                8'hc2:                       info.imm = imm_2;    // ret imm16
                8'h9a:                       info.imm = imm_far;  // call ptr16:32
                default:                     info.legal = 1'b0;
            endcase
        end
        return info;
    endfunction

endpackage

`default_nettype wire

//--- rtl/decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module decode_top
    import decode_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid_in,
    input  logic [8*packet_bytes-1:0] packet_in,
    input  logic [eip_w-1:0]          init_eip,
    input  logic [eip_w-1:0]          wb_eip,
    input  logic [eip_w-1:0]          bp_eip,
    input  logic                      is_init,
    input  logic                      is_resteer,
    input  logic                      is_br_taken,
    input  logic                      queue_full_stall,
    output logic                      stall_out,
    output logic                      valid_out,
    output logic [eip_w-1:0]          eip_out,
    output logic [len_w-1:0]          length_out,
    output logic                      rep_out,
    output logic                      opsize16_out,
    output logic                      seg_ovr_out,
    output logic [2:0]                seg_out,
    output logic [7:0]                opcode_out,
    output logic                      is_double_out,
    output logic                      illegal_out,
    output logic                      has_modrm_out,
    output logic [2:0]                reg_out,
    output logic [2:0]                base_out,
    output logic                      use_base_out,
    output logic [2:0]                index_out,
    output logic                      use_index_out,
    output logic [1:0]                scale_out,
    output logic [disp_w-1:0]         disp_out,
    output logic [imm_w-1:0]          imm_out
);

    //////////////////////////////////////////////////
    // links between the three stages
    //////////////////////////////////////////////////

    stage_link #(.payload_t(prefix_info_t)) pre_link ();
    stage_link #(.payload_t(decoded_t))     dec_link ();

    assign stall_out = queue_full_stall;  // fetch holds its packet

    prefix_stage u_prefix (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .packet_in (packet_in),
        .stall     (pre_link.stall),   // same level as the queue stall
        .out       (pre_link)
    );

    opcode_stage u_opcode (
        .clk   (clk),
        .reset (reset),
        .in    (pre_link),
        .out   (dec_link)
    );

    // output fields and redirects match by name
    extract_stage u_extract (
        .stall (queue_full_stall),
        .in    (dec_link),
        .*
    );

endmodule

`default_nettype wire

//--- rtl/extract_stage.sv
`timescale 1ns/100ps
`default_nettype none

module extract_stage
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    stage_link.dst            in,
    input  logic [eip_w-1:0]  init_eip,
    input  logic [eip_w-1:0]  wb_eip,
    input  logic [eip_w-1:0]  bp_eip,
    input  logic              is_init,
    input  logic              is_resteer,
    input  logic              is_br_taken,
    output logic              valid_out,
    output logic [eip_w-1:0]  eip_out,
    output logic [len_w-1:0]  length_out,
    output logic              rep_out,
    output logic              opsize16_out,
    output logic              seg_ovr_out,
    output logic [2:0]        seg_out,
    output logic [7:0]        opcode_out,
    output logic              is_double_out,
    output logic              illegal_out,
    output logic              has_modrm_out,
    output logic [2:0]        reg_out,
    output logic [2:0]        base_out,
    output logic              use_base_out,
    output logic [2:0]        index_out,
    output logic              use_index_out,
    output logic [1:0]        scale_out,
    output logic [disp_w-1:0] disp_out,
    output logic [imm_w-1:0]  imm_out
);

    decoded_t          d;
    logic [disp_w-1:0] disp_raw, disp_val;
    logic [imm_w-1:0]  imm_val;
    logic [eip_w-1:0]  eip_q;

    assign d        = in.payload;
    assign in.stall = stall;   // last stage sees the queue directly

    // past the packet end reads as zero
    function automatic logic [7:0] pick(input packet_t pkt, input logic [4:0] idx);
        return (idx < 5'(packet_bytes)) ? pkt[idx[3:0]] : 8'h00;
    endfunction

    //////////////////////////////////////////////////
    // little endian extraction
    //////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < disp_w / 8; k++) begin
            disp_raw[8*k +: 8] = pick(in.packet, {1'b0, d.disp_off} + 5'(k));
        end
        case (d.disp_size)
            3'd1:    disp_val = {{(disp_w-8){disp_raw[7]}}, disp_raw[7:0]};  // sign ext
            3'd4:    disp_val = disp_raw;
            default: disp_val = '0;
        endcase
    end

    always_comb begin
        for (int k = 0; k < imm_w / 8; k++) begin
            imm_val[8*k +: 8] = (3'(k) < d.imm_size) ?
                                pick(in.packet, {1'b0, d.imm_off} + 5'(k)) : 8'h00;
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset)       valid_out <= 1'b0;
        else if (!stall) valid_out <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            length_out    <= d.length;
            rep_out       <= d.pfx.rep;
            opsize16_out  <= d.pfx.opsize16;
            seg_ovr_out   <= d.pfx.seg_ovr;
            seg_out       <= d.pfx.seg;
            opcode_out    <= d.opcode;
            is_double_out <= d.is_double;
            illegal_out   <= d.illegal;
            has_modrm_out <= d.has_modrm;
            reg_out       <= d.reg_num;
            base_out      <= d.base;
            use_base_out  <= d.use_base;
            index_out     <= d.index;
            use_index_out <= d.use_index;
            scale_out     <= d.scale;
            disp_out      <= disp_val;
            imm_out       <= imm_val;
        end
    end

    // eip, redirects win over the length step even under stall
    always_ff @(posedge clk) begin
        if (reset)                    eip_q <= '0;
        else if (is_init)             eip_q <= init_eip;
        else if (is_resteer)          eip_q <= wb_eip;
        else if (is_br_taken)         eip_q <= bp_eip;
        else if (valid_out && !stall) eip_q <= eip_q + {{(eip_w-len_w){1'b0}}, length_out};
    end

    assign eip_out = eip_q;

    // redirect sources are exclusive by protocol
    a_one_redirect: assert property (@(posedge clk) disable iff (reset)
        $onehot0({is_init, is_resteer, is_br_taken}));

endmodule

`default_nettype wire

//--- rtl/opcode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module opcode_stage
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    stage_link.dst in,
    stage_link.src out
);

    prefix_info_t     pfx;
    op_info_t         info;
    decoded_t         dec;
    logic [3:0]       op_pos, modrm_pos;
    logic             is_dbl, has_modrm, has_sib;
    logic [7:0]       opc, modrm, sib;
    logic [2:0]       disp_size, imm_size;
    logic [len_w-1:0] disp_off, imm_off, total_len;

    assign in.stall = out.stall;   // stall passes straight up

    //////////////////////////////////////////////////
    // opcode select and table
    //////////////////////////////////////////////////

    assign pfx       = in.payload;
    assign op_pos    = {2'b00, pfx.num_prefixes};
    assign is_dbl    = (in.packet[op_pos] == op_escape);
    assign opc       = is_dbl ? in.packet[op_pos + 4'd1] : in.packet[op_pos];
    assign info      = op_lookup(is_dbl, opc);
    assign modrm_pos = op_pos + 4'd1 + {3'b000, is_dbl};
    assign modrm     = in.packet[modrm_pos];
    assign sib       = in.packet[modrm_pos + 4'd1];
    assign has_modrm = info.modrm && info.legal;
    assign has_sib   = has_modrm && (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'b100);

    // 32-bit addressing only
    always_comb begin
        case (modrm[7:6])
            2'b00:   disp_size = ((modrm[2:0] == 3'b101) ||
                                  (has_sib && sib[2:0] == 3'b101)) ? 3'd4 : 3'd0;
            2'b01:   disp_size = 3'd1;   // disp8
            2'b10:   disp_size = 3'd4;
            default: disp_size = 3'd0;   // register operand
        endcase
        if (!has_modrm) disp_size = 3'd0;
        case (info.imm)
            imm_1:   imm_size = 3'd1;
            imm_2:   imm_size = 3'd2;
            imm_v:   imm_size = pfx.opsize16 ? 3'd2 : 3'd4;
            imm_far: imm_size = pfx.opsize16 ? 3'd4 : 3'd6;  // offset + selector
            default: imm_size = 3'd0;
        endcase
    end

    // offsets chain from the opcode end
    assign disp_off  = {1'b0, modrm_pos} + len_w'(has_modrm) + len_w'(has_sib);
    assign imm_off   = disp_off + len_w'(disp_size);
    assign total_len = imm_off + len_w'(imm_size);

    always_comb begin
        dec           = '0;
        dec.pfx       = pfx;
        dec.opcode    = opc;
        dec.is_double = is_dbl;
        dec.has_modrm = has_modrm;
        dec.illegal   = !info.legal;
        dec.disp_off  = disp_off[3:0];
        dec.disp_size = disp_size;
        dec.imm_off   = imm_off[3:0];
        dec.imm_size  = imm_size;
        dec.length    = info.legal ? total_len : len_w'(pfx.num_prefixes) + len_w'(1);
        if (has_modrm) begin
            dec.reg_num  = modrm[5:3];
            dec.base     = has_sib ? sib[2:0] : modrm[2:0];
            dec.use_base = !(modrm[7:6] == 2'b00 && dec.base == 3'b101);  // disp32 only
        end
        if (has_sib) begin
            dec.index     = sib[5:3];
            dec.use_index = (sib[5:3] != 3'b100);  // 100 means none
            dec.scale     = sib[7:6];
        end
    end

    //////////////////////////////////////////////////
    // stage register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset)           out.valid <= 1'b0;
        else if (!out.stall) out.valid <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (!out.stall) begin
            out.packet  <= in.packet;
            out.payload <= dec;
        end
    end

    a_len_fits: assert property (@(posedge clk) disable iff (reset)
        out.valid |-> out.payload.length <= len_w'(packet_bytes));

endmodule

`default_nettype wire

//--- rtl/prefix_stage.sv
`timescale 1ns/100ps
`default_nettype none

module prefix_stage
    import decode_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    valid_in,
    input  packet_t packet_in,
    input  logic    stall,
    stage_link.src  out
);

    prefix_info_t info;
    logic         scanning;   // still inside the prefix run

    function automatic seg_e seg_of(input logic [7:0] b);
        case (b)
            pfx_cs:  return seg_cs;
            pfx_ss:  return seg_ss;
            pfx_ds:  return seg_ds;
            pfx_fs:  return seg_fs;
            pfx_gs:  return seg_gs;
            default: return seg_es;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // prefix scan over bytes 0..2
    //////////////////////////////////////////////////

    always_comb begin
        info     = '0;
        scanning = 1'b1;
        for (int i = 0; i < max_prefixes; i++) begin
            if (scanning) begin
                case (packet_in[i])
                    pfx_rep:    info.rep      = 1'b1;
                    pfx_opsize: info.opsize16 = 1'b1;
                    pfx_es, pfx_cs, pfx_ss, pfx_ds, pfx_fs, pfx_gs: begin
                        info.seg_ovr = 1'b1;
                        info.seg     = seg_of(packet_in[i]);  // last one wins
                    end
                    default:    scanning = 1'b0;              // opcode reached
                endcase
                if (scanning) info.num_prefixes = 2'(i + 1);
            end
        end
    end

    //////////////////////////////////////////////////
    // stage register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset)       out.valid <= 1'b0;
        else if (!stall) out.valid <= valid_in;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out.packet  <= packet_in;
            out.payload <= info;
        end
    end

    // a packet offered under stall must wait at the input, or it is lost
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        (stall && valid_in) |=> (valid_in && $stable(packet_in)));

endmodule

`default_nettype wire

//--- rtl/stage_link.sv
`timescale 1ns/100ps
`default_nettype none

// one stage output to the next, stall flows back
interface stage_link
    import decode_pkg::*;
#(
    parameter type payload_t = logic
) ();

    logic     valid;
    packet_t  packet;
    payload_t payload;
    logic     stall;   // driven by the consumer

    modport src (output valid, output packet, output payload, input stall);
    modport dst (input valid, input packet, input payload, output stall);

endinterface

`default_nettype wire

//--- tests/decode_vectors.txt
# packet bytes 0..15, len rep opsize seg_ovr seg opcode is_double illegal has_modrm
# reg base use_base index use_index scale disp imm; I, R or B with an address redirects eip
I 00001000
90c1c2c3c4c5c6c7c8c9cacbcccdcecf 01 0 0 0 0 90 0 0 0 0 0 0 0 0 0 00000000 000000000000
0578563412c5c6c7c8c9cacbcccdcecf 05 0 0 0 0 05 0 0 0 0 0 0 0 0 0 00000000 000012345678
66053412c4c5c6c7c8c9cacbcccdcecf 04 0 1 0 0 05 0 0 0 0 0 0 0 0 0 00000000 000000001234
047fc2c3c4c5c6c7c8c9cacbcccdcecf 02 0 0 0 0 04 0 0 0 0 0 0 0 0 0 00000000 00000000007f
01d8c2c3c4c5c6c7c8c9cacbcccdcecf 02 0 0 0 0 01 0 0 1 3 0 1 0 0 0 00000000 000000000000
8b45f8c3c4c5c6c7c8c9cacbcccdcecf 03 0 0 0 0 8b 0 0 1 0 5 1 0 0 0 fffffff8 000000000000
890544332211c6c7c8c9cacbcccdcecf 06 0 0 0 0 89 0 0 1 0 5 0 0 0 0 11223344 000000000000
8b848e78563412c7c8c9cacbcccdcecf 07 0 0 0 0 8b 0 0 1 0 6 1 1 1 2 12345678 000000000000
8b442410c4c5c6c7c8c9cacbcccdcecf 04 0 0 0 0 8b 0 0 1 0 4 1 4 0 0 00000010 000000000000
8b04cd00100000c7c8c9cacbcccdcecf 07 0 0 0 0 8b 0 0 1 0 5 0 1 1 3 00001000 000000000000
81c1efbeaddec6c7c8c9cacbcccdcecf 06 0 0 0 0 81 0 0 1 0 1 1 0 0 0 00000000 0000deadbeef
668145083412c6c7c8c9cacbcccdcecf 06 0 1 0 0 81 0 0 1 0 5 1 0 0 0 00000008 000000001234
837dfc05c4c5c6c7c8c9cacbcccdcecf 04 0 0 0 0 83 0 0 1 7 5 1 0 0 0 fffffffc 000000000005
R 00400000
803c3380c4c5c6c7c8c9cacbcccdcecf 04 0 0 0 0 80 0 0 1 7 3 1 6 1 0 00000000 000000000080
bb01000080c5c6c7c8c9cacbcccdcecf 05 0 0 0 0 bb 0 0 0 0 0 0 0 0 0 00000000 000080000001
c20800c3c4c5c6c7c8c9cacbcccdcecf 03 0 0 0 0 c2 0 0 0 0 0 0 0 0 0 00000000 000000000008
c3c1c2c3c4c5c6c7c8c9cacbcccdcecf 01 0 0 0 0 c3 0 0 0 0 0 0 0 0 0 00000000 000000000000
53c1c2c3c4c5c6c7c8c9cacbcccdcecf 01 0 0 0 0 53 0 0 0 0 0 0 0 0 0 00000000 000000000000
9a78563412cdabc7c8c9cacbcccdcecf 07 0 0 0 0 9a 0 0 0 0 0 0 0 0 0 00000000 abcd12345678
669a3412cdabc6c7c8c9cacbcccdcecf 06 0 1 0 0 9a 0 0 0 0 0 0 0 0 0 00000000 0000abcd1234
0f8410203040c6c7c8c9cacbcccdcecf 06 0 0 0 0 84 1 0 0 0 0 0 0 0 0 00000000 000040302010
B 7ffffff0
f3266490c4c5c6c7c8c9cacbcccdcecf 04 1 0 1 4 90 0 0 0 0 0 0 0 0 0 00000000 000000000000
3e66e8feffc5c6c7c8c9cacbcccdcecf 05 0 1 1 3 e8 0 0 0 0 0 0 0 0 0 00000000 00000000fffe
2e3665eb10c5c6c7c8c9cacbcccdcecf 05 0 0 1 5 eb 0 0 0 0 0 0 0 0 0 00000000 000000000010
66f4c2c3c4c5c6c7c8c9cacbcccdcecf 02 0 1 0 0 f4 0 1 0 0 0 0 0 0 0 00000000 000000000000
0f05c2c3c4c5c6c7c8c9cacbcccdcecf 01 0 0 0 0 05 1 1 0 0 0 0 0 0 0 00000000 000000000000
648184884433221178563412cccdcecf 0c 0 0 1 4 81 0 0 1 0 0 1 1 1 2 11223344 000012345678

//--- tests/tb_decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_top
    import decode_pkg::*;
();

    logic                clk = 1'b0;
    logic                reset;
    logic                valid_in;
    logic [127:0]        packet_in;
    logic [eip_w-1:0]    init_eip;
    logic [eip_w-1:0]    wb_eip;
    logic [eip_w-1:0]    bp_eip;
    logic                is_init;
    logic                is_resteer;
    logic                is_br_taken;
    logic                queue_full_stall = 1'b0;
    logic                stall_out;
    logic                valid_out;
    logic [eip_w-1:0]    eip_out;
    logic [len_w-1:0]    length_out;
    logic                rep_out;
    logic                opsize16_out;
    logic                seg_ovr_out;
    logic [2:0]          seg_out;
    logic [7:0]          opcode_out;
    logic                is_double_out;
    logic                illegal_out;
    logic                has_modrm_out;
    logic [2:0]          reg_out;
    logic [2:0]          base_out;
    logic                use_base_out;
    logic [2:0]          index_out;
    logic                use_index_out;
    logic [1:0]          scale_out;
    logic [disp_w-1:0]   disp_out;
    logic [imm_w-1:0]    imm_out;

    // one instruction's fields, in vector file column order
    typedef struct packed {
        logic [len_w-1:0]  length;
        logic              rep;
        logic              opsize16;
        logic              seg_ovr;
        logic [2:0]        seg;
        logic [7:0]        opcode;
        logic              is_double;
        logic              illegal;
        logic              has_modrm;
        logic [2:0]        reg_num;
        logic [2:0]        base;
        logic              use_base;
        logic [2:0]        index;
        logic              use_index;
        logic [1:0]        scale;
        logic [disp_w-1:0] disp;
        logic [imm_w-1:0]  imm;
    } fields_t;

    fields_t          exp_q[$];          // in flight, oldest first
    fields_t          act;
    fields_t          snap;              // outputs one cycle back
    logic             snap_valid = 1'b0;
    logic             was_stalled = 1'b0;
    logic [eip_w-1:0] exp_eip = '0;      // redirect base plus lengths

    assign act = {length_out, rep_out, opsize16_out, seg_ovr_out, seg_out, opcode_out,
                  is_double_out, illegal_out, has_modrm_out, reg_out, base_out,
                  use_base_out, index_out, use_index_out, scale_out, disp_out, imm_out};

    decode_top UUT (.*);

    always #10 clk = ~clk;

    // queue full about one cycle in four
    always @(posedge clk) begin
        if (reset) queue_full_stall <= 1'b0;
        else       queue_full_stall <= ($urandom_range(3) == 0);
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
        assert (act_v === exp_v) else begin
            $display("FAILED time %0t ns signal %s expected %0h actual %0h",
                     $time, name, exp_v, act_v);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_outputs(input fields_t e);
        check_value("eip_out", exp_eip, eip_out);
        check_value("length_out", e.length, length_out);
        check_value("rep_out", e.rep, rep_out);
        check_value("opsize16_out", e.opsize16, opsize16_out);
        check_value("seg_ovr_out", e.seg_ovr, seg_ovr_out);
        check_value("seg_out", e.seg, seg_out);
        check_value("opcode_out", e.opcode, opcode_out);
        check_value("is_double_out", e.is_double, is_double_out);
        check_value("illegal_out", e.illegal, illegal_out);
        check_value("has_modrm_out", e.has_modrm, has_modrm_out);
        check_value("reg_out", e.reg_num, reg_out);
        check_value("base_out", e.base, base_out);
        check_value("use_base_out", e.use_base, use_base_out);
        check_value("index_out", e.index, index_out);
        check_value("use_index_out", e.use_index, use_index_out);
        check_value("scale_out", e.scale, scale_out);
        check_value("disp_out", e.disp, disp_out);
        check_value("imm_out", e.imm, imm_out);
        exp_eip = exp_eip + e.length;   // next instruction starts here
    endtask

    // sampled mid cycle, away from the driving edge
    always @(negedge clk) begin
        if (!reset) begin
            check_value("stall_out", queue_full_stall, stall_out);
            if (was_stalled) begin                       // frozen by last stall
                check_value("valid_out held", snap_valid, valid_out);
                check_value("outputs held", snap, act);
            end
            if (valid_out && !queue_full_stall) begin    // leaves on next edge
                assert (exp_q.size() != 0) else begin
                    $display("valid_out high at %0t ns with nothing in flight", $time);
                    $display("RESULT: FAIL");
                    $fatal(1, "unexpected instruction");
                end
                compare_outputs(exp_q.pop_front());
            end
        end
        was_stalled = queue_full_stall && !reset;
        snap        = act;
        snap_valid  = valid_out;
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // held until an edge with the queue not full
    task automatic send_packet(input logic [127:0] pkt);
        int waited;
        valid_in  <= 1'b1;
        packet_in <= pkt;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            assert (waited < 200) else begin
                $display("RESULT: FAIL");
                $fatal(1, "packet never accepted, stall stuck high");
            end
        end while (queue_full_stall);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            assert (waited < 500) else begin
                $display("RESULT: FAIL");
                $fatal(1, "pipeline never drained, instructions missing at output");
            end
        end
    endtask

    initial begin
        string            tok;
        logic [8*100-1:0] rest;
        logic [127:0]     pkt;
        logic [63:0]      v [17];
        logic [31:0]      addr;
        fields_t          e;
        integer           fd;
        integer           n;
        n           = $urandom(32'h1d8e99a7);
        reset       = 1'b1;
        valid_in    = 1'b0;
        packet_in   = '0;
        init_eip    = '0;
        wb_eip      = '0;
        bp_eip      = '0;
        is_init     = 1'b0;
        is_resteer  = 1'b0;
        is_br_taken = 1'b0;
        fd = $fopen("tests/decode_vectors.txt", "r");
        assert (fd != 0) else begin
            $display("RESULT: FAIL");
            $fatal(1, "cannot open tests/decode_vectors.txt");
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(rest, fd);                   // comment line
            end else if (tok == "I" || tok == "R" || tok == "B") begin
                n = $fscanf(fd, "%h", addr);
                valid_in <= 1'b0;
                wait_drained();                         // redirect on an empty pipe
                init_eip    <= (tok == "I") ? addr : ~addr;  // wrong source shows up
                wb_eip      <= (tok == "R") ? addr : ~addr;
                bp_eip      <= (tok == "B") ? addr : ~addr;
                is_init     <= (tok == "I");
                is_resteer  <= (tok == "R");
                is_br_taken <= (tok == "B");
                exp_eip = addr;
                @(posedge clk);
                is_init     <= 1'b0;
                is_resteer  <= 1'b0;
                is_br_taken <= 1'b0;
            end else begin
                n = $sscanf(tok, "%h", pkt);
                for (int i = 0; i < 17; i++) n = $fscanf(fd, "%h", v[i]);
                e = {v[0][len_w-1:0], v[1][0], v[2][0], v[3][0], v[4][2:0], v[5][7:0],
                     v[6][0], v[7][0], v[8][0], v[9][2:0], v[10][2:0], v[11][0],
                     v[12][2:0], v[13][0], v[14][1:0], v[15][31:0], v[16][47:0]};
                exp_q.push_back(e);
                send_packet(pkt);
            end
        end
        $fclose(fd);
        valid_in <= 1'b0;
        wait_drained();
        repeat (5) @(posedge clk);                      // valid_out must stay low
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
